//--- mm_consts.svh
`ifndef MM_CONSTS_SVH
`define MM_CONSTS_SVH

// Matrix dimension N and element width
`define MAT_SIZE 4
`define DWIDTH 8

// RAM geometry
`define AWIDTH 4
`define MEM_DEPTH 16

// One RAM word carries a full row or column
`define ROW_WIDTH (`MAT_SIZE * `DWIDTH)

`endif

//--- mm_pkg.sv
`default_nettype none

`include "mm_consts.svh"

package mm_pkg;

  // One matrix element
  typedef logic [`DWIDTH-1:0] elem_t;

  // Element 0 sits in the low bits
  typedef logic [`ROW_WIDTH-1:0] row_t;

  typedef logic [`AWIDTH-1:0] addr_t;

  // Controller sequence, in run order
  typedef enum logic [2:0] {
    IDLE,
    FEED,
    DRAIN,
    STORE,
    FINISH
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- bank_ram.sv
`timescale 1ns/10ps
`default_nettype none

`include "mm_consts.svh"

module bank_ram (
  input  wire logic          clk_mem,
  input  wire mm_pkg::addr_t addr,
  input  wire mm_pkg::row_t  d,
  input  wire logic          we,
  output mm_pkg::row_t       q
);

  mm_pkg::row_t mem [`MEM_DEPTH];

  // Read-before-write, old word comes out on a write cycle
  always_ff @(posedge clk_mem) begin
    q <= mem[addr];
    if (we) begin
      mem[addr] <= d;
    end
  end

endmodule

`default_nettype wire

//--- mac_pe.sv
`timescale 1ns/10ps
`default_nettype none

`include "mm_consts.svh"

module mac_pe (
  input  wire logic          clk_mem,
  input  wire logic          reset,
  input  wire logic          clear_acc,
  input  wire logic          valid_in,
  input  wire mm_pkg::elem_t a_in,
  input  wire mm_pkg::elem_t b_in,
  output mm_pkg::elem_t      a_out,
  output mm_pkg::elem_t      b_out,
  output logic               valid_out,
  output mm_pkg::elem_t      acc
);

  mm_pkg::elem_t prod;

  // Only the low byte of each product matters for a wrapping sum
  assign prod = a_in * b_in;

  // Operands march right and down every cycle
  always_ff @(posedge clk_mem) begin
    a_out <= a_in;
    b_out <= b_in;
  end

  always_ff @(posedge clk_mem) begin
    if (reset) begin
      valid_out <= 1'b0;
      acc       <= '0;
    end else begin
      valid_out <= valid_in;
      if (clear_acc) begin
        acc <= '0;
      end else if (valid_in) begin
        acc <= acc + prod;
      end
    end
  end

endmodule

`default_nettype wire

//--- systolic_array.sv
`timescale 1ns/10ps
`default_nettype none

`include "mm_consts.svh"

module systolic_array (
  input  wire logic          clk_mem,
  input  wire logic          reset,
  input  wire logic          clear_acc,
  input  wire logic          feed_valid,
  input  wire mm_pkg::row_t  a_col,
  input  wire mm_pkg::row_t  b_row,
  input  wire mm_pkg::addr_t c_row_sel,
  output mm_pkg::row_t       c_row
);

  // Skewed operands at the left and top edges
  wire mm_pkg::elem_t a_skew [`MAT_SIZE];
  wire mm_pkg::elem_t b_skew [`MAT_SIZE];
  wire [`MAT_SIZE-1:0] v_skew;
  logic [`MAT_SIZE-2:0] v_pipe;

  // Links between neighbouring PEs
  wire mm_pkg::elem_t a_link [`MAT_SIZE][`MAT_SIZE];
  wire mm_pkg::elem_t b_link [`MAT_SIZE][`MAT_SIZE];
  wire v_link [`MAT_SIZE][`MAT_SIZE];
  wire mm_pkg::elem_t acc [`MAT_SIZE][`MAT_SIZE];

  //////////////////////////////////////////////////////////////////////
  // Input skew
  //////////////////////////////////////////////////////////////////////

  // Valid tap i is feed_valid delayed i cycles
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      v_pipe <= '0;
    end else begin
      v_pipe <= {v_pipe[`MAT_SIZE-3:0], feed_valid};
    end
  end

  for (genvar gi = 0; gi < `MAT_SIZE; gi++) begin : g_skew
    if (gi == 0) begin : g_edge
      assign a_skew[gi] = a_col[gi*`DWIDTH +: `DWIDTH];
      assign b_skew[gi] = b_row[gi*`DWIDTH +: `DWIDTH];
      assign v_skew[gi] = feed_valid;
    end else begin : g_delay
      mm_pkg::elem_t a_dly [gi];
      mm_pkg::elem_t b_dly [gi];

      // Element gi waits gi cycles
      always_ff @(posedge clk_mem) begin
        a_dly[0] <= a_col[gi*`DWIDTH +: `DWIDTH];
        b_dly[0] <= b_row[gi*`DWIDTH +: `DWIDTH];
        for (int s = 1; s < gi; s++) begin
          a_dly[s] <= a_dly[s-1];
          b_dly[s] <= b_dly[s-1];
        end
      end

      assign a_skew[gi] = a_dly[gi-1];
      assign b_skew[gi] = b_dly[gi-1];
      assign v_skew[gi] = v_pipe[gi-1];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // PE grid
  //////////////////////////////////////////////////////////////////////

  for (genvar gi = 0; gi < `MAT_SIZE; gi++) begin : g_row
    for (genvar gj = 0; gj < `MAT_SIZE; gj++) begin : g_col
      wire mm_pkg::elem_t a_in;
      wire mm_pkg::elem_t b_in;
      wire v_in;

      // Valid travels with A, along the row
      if (gj == 0) begin : g_left
        assign a_in = a_skew[gi];
        assign v_in = v_skew[gi];
      end else begin : g_inner_a
        assign a_in = a_link[gi][gj-1];
        assign v_in = v_link[gi][gj-1];
      end

      if (gi == 0) begin : g_top
        assign b_in = b_skew[gj];
      end else begin : g_inner_b
        assign b_in = b_link[gi-1][gj];
      end

      mac_pe u_pe (
        .clk_mem   (clk_mem),
        .reset     (reset),
        .clear_acc (clear_acc),
        .valid_in  (v_in),
        .a_in      (a_in),
        .b_in      (b_in),
        .a_out     (a_link[gi][gj]),
        .b_out     (b_link[gi][gj]),
        .valid_out (v_link[gi][gj]),
        .acc       (acc[gi][gj])
      );
    end
  end

  // Result row picked for the C write
  always_comb begin
    c_row = '0;
    for (int r = 0; r < `MAT_SIZE; r++) begin
      if (c_row_sel == mm_pkg::addr_t'(r)) begin
        for (int c = 0; c < `MAT_SIZE; c++) begin
          c_row[c*`DWIDTH +: `DWIDTH] = acc[r][c];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- mat_mul_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "mm_consts.svh"

module mat_mul_ctrl (
  input  wire logic     clk_mem,
  input  wire logic     reset,
  input  wire logic     start_mat_mul,
  output mm_pkg::addr_t op_addr,
  output logic          feed_valid,
  output logic          clear_acc,
  output mm_pkg::addr_t c_row_sel,
  output logic          c_we,
  output mm_pkg::addr_t c_addr,
  output logic          done_mat_mul
);

  localparam mm_pkg::addr_t LAST_ROW   = mm_pkg::addr_t'(`MAT_SIZE - 1);
  localparam mm_pkg::addr_t LAST_DRAIN = mm_pkg::addr_t'(2 * `MAT_SIZE - 1);

  mm_pkg::ctrl_state_t state;
  mm_pkg::addr_t       cnt;

  always_ff @(posedge clk_mem) begin
    if (reset) begin
      state      <= mm_pkg::IDLE;
      cnt        <= '0;
      clear_acc  <= 1'b0;
      feed_valid <= 1'b0;
    end else begin
      clear_acc <= 1'b0;
      // RAM output lags the address by one cycle
      feed_valid <= (state == mm_pkg::FEED);
      case (state)
        mm_pkg::IDLE: begin
          if (start_mat_mul) begin
            state     <= mm_pkg::FEED;
            cnt       <= '0;
            clear_acc <= 1'b1;
          end
        end
        mm_pkg::FEED: begin
          if (cnt == LAST_ROW) begin
            state <= mm_pkg::DRAIN;
            cnt   <= '0;
          end else begin
            cnt <= cnt + mm_pkg::addr_t'(1);
          end
        end
        // Let the last operands reach the far corner
        mm_pkg::DRAIN: begin
          if (cnt == LAST_DRAIN) begin
            state <= mm_pkg::STORE;
            cnt   <= '0;
          end else begin
            cnt <= cnt + mm_pkg::addr_t'(1);
          end
        end
        mm_pkg::STORE: begin
          if (cnt == LAST_ROW) begin
            state <= mm_pkg::FINISH;
            cnt   <= '0;
          end else begin
            cnt <= cnt + mm_pkg::addr_t'(1);
          end
        end
        default: begin
          state <= mm_pkg::IDLE;
        end
      endcase
    end
  end

  // One counter walks operand words, then result rows
  assign op_addr      = cnt;
  assign c_row_sel    = cnt;
  assign c_addr       = cnt;
  assign c_we         = (state == mm_pkg::STORE);
  assign done_mat_mul = (state == mm_pkg::FINISH);

  // A run is at least 4N cycles, so done pulses stay well apart
  assert property (@(posedge clk_mem) disable iff (reset)
    done_mat_mul |=> !done_mat_mul [* 4*`MAT_SIZE]);

  // Every C write belongs to STORE and is closed by done
  assert property (@(posedge clk_mem) disable iff (reset)
    c_we |-> (state == mm_pkg::STORE) ##[1:`MAT_SIZE] done_mat_mul);

endmodule

`default_nettype wire

//--- mat_mul_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "mm_consts.svh"

module mat_mul_top (
  input  wire logic          clk_mem,
  input  wire logic          reset,
  input  wire logic          enable_writing_to_mem,
  input  wire logic          enable_reading_from_mem,
  input  wire mm_pkg::addr_t addr_pi,
  input  wire mm_pkg::row_t  data_pi,
  input  wire logic          we_a,
  input  wire logic          we_b,
  input  wire logic          start_mat_mul,
  output mm_pkg::row_t       data_from_out_mat,
  output logic               done_mat_mul
);

  logic          wr_en_q;
  logic          rd_en_q;
  logic          we_a_q;
  logic          we_b_q;
  mm_pkg::addr_t addr_q;
  mm_pkg::row_t  data_q;

  mm_pkg::addr_t op_addr;
  mm_pkg::addr_t c_row_sel;
  mm_pkg::addr_t c_addr;
  logic          feed_valid;
  logic          clear_acc;
  logic          c_we;

  mm_pkg::addr_t ab_addr;
  mm_pkg::addr_t c_mux_addr;
  mm_pkg::row_t  a_q;
  mm_pkg::row_t  b_q;
  mm_pkg::row_t  c_q;
  mm_pkg::row_t  c_row;

  //////////////////////////////////////////////////////////////////////
  // Host port registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_mem) begin
    if (reset) begin
      wr_en_q <= 1'b0;
      rd_en_q <= 1'b0;
      we_a_q  <= 1'b0;
      we_b_q  <= 1'b0;
    end else begin
      wr_en_q <= enable_writing_to_mem;
      rd_en_q <= enable_reading_from_mem;
      we_a_q  <= we_a;
      we_b_q  <= we_b;
    end
  end

  always_ff @(posedge clk_mem) begin
    addr_q <= addr_pi;
    data_q <= data_pi;
  end

  // Host owns the RAM address while its enable is up
  assign ab_addr    = wr_en_q ? addr_q : op_addr;
  assign c_mux_addr = rd_en_q ? addr_q : c_addr;

  //////////////////////////////////////////////////////////////////////
  // Operand and result RAMs
  //////////////////////////////////////////////////////////////////////

  bank_ram a_ram (
    .clk_mem (clk_mem),
    .addr    (ab_addr),
    .d       (data_q),
    .we      (we_a_q & wr_en_q),
    .q       (a_q)
  );

  bank_ram b_ram (
    .clk_mem (clk_mem),
    .addr    (ab_addr),
    .d       (data_q),
    .we      (we_b_q & wr_en_q),
    .q       (b_q)
  );

  bank_ram c_ram (
    .clk_mem (clk_mem),
    .addr    (c_mux_addr),
    .d       (c_row),
    .we      (c_we),
    .q       (c_q)
  );

  // Third stage of the read path
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      data_from_out_mat <= '0;
    end else begin
      data_from_out_mat <= c_q;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Compute engine
  //////////////////////////////////////////////////////////////////////

  mat_mul_ctrl u_ctrl (
    .clk_mem       (clk_mem),
    .reset         (reset),
    .start_mat_mul (start_mat_mul),
    .op_addr       (op_addr),
    .feed_valid    (feed_valid),
    .clear_acc     (clear_acc),
    .c_row_sel     (c_row_sel),
    .c_we          (c_we),
    .c_addr        (c_addr),
    .done_mat_mul  (done_mat_mul)
  );

  // A columns enter from the left, B rows from the top
  systolic_array u_array (
    .clk_mem    (clk_mem),
    .reset      (reset),
    .clear_acc  (clear_acc),
    .feed_valid (feed_valid),
    .a_col      (a_q),
    .b_row      (b_q),
    .c_row_sel  (c_row_sel),
    .c_row      (c_row)
  );

  // Host writes and reads share one address register
  assert property (@(posedge clk_mem) disable iff (reset)
    !(enable_writing_to_mem && enable_reading_from_mem));

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
  output logic clk_mem
);

  // 20 ns period
  localparam int HALF_PERIOD = 10;

  initial begin
    clk_mem = 1'b0;
    forever #HALF_PERIOD clk_mem = ~clk_mem;
  end

endmodule

`default_nettype wire

//--- mat_mul_top_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "mm_consts.svh"

module mat_mul_top_tb;

  localparam int N           = `MAT_SIZE;
  localparam int NUM_CASES   = 5;
  localparam int DONE_LIMIT  = 4 * N + 8;
  localparam int CYCLE_LIMIT = NUM_CASES * (2 * N + 4 * N + 8 + 4 * N) + 50;
  localparam int MODE_PLAIN   = 0;
  localparam int MODE_RESTART = 1;

  wire           clk_mem;
  logic          reset;
  logic          enable_writing_to_mem;
  logic          enable_reading_from_mem;
  mm_pkg::addr_t addr_pi;
  mm_pkg::row_t  data_pi;
  logic          we_a;
  logic          we_b;
  logic          start_mat_mul;
  mm_pkg::row_t  data_from_out_mat;
  logic          done_mat_mul;

  // Case table with expected C rows from build_table
  mm_pkg::elem_t tbl_a [NUM_CASES][N][N];
  mm_pkg::elem_t tbl_b [NUM_CASES][N][N];
  int            tbl_mode [NUM_CASES];
  mm_pkg::row_t  tbl_c [NUM_CASES][N];

  integer seed = 80585;
  int     value_errs = 0;
  int     other_errs = 0;
  int     cycles = 0;

  tb_clock_gen u_clk (
    .clk_mem (clk_mem)
  );

  mat_mul_top uut (
    .clk_mem                 (clk_mem),
    .reset                   (reset),
    .enable_writing_to_mem   (enable_writing_to_mem),
    .enable_reading_from_mem (enable_reading_from_mem),
    .addr_pi                 (addr_pi),
    .data_pi                 (data_pi),
    .we_a                    (we_a),
    .we_b                    (we_b),
    .start_mat_mul           (start_mat_mul),
    .data_from_out_mat       (data_from_out_mat),
    .done_mat_mul            (done_mat_mul)
  );

  //////////////////////////////////////////////////////////////////////
  // Table and reference model
  //////////////////////////////////////////////////////////////////////

  task automatic build_table();
    mm_pkg::elem_t sum;
    for (int c = 0; c < NUM_CASES; c++) begin
      tbl_mode[c] = (c == 4) ? MODE_RESTART : MODE_PLAIN;
      for (int i = 0; i < N; i++) begin
        for (int j = 0; j < N; j++) begin
          case (c)
            0: tbl_a[c][i][j] = (i == j) ? mm_pkg::elem_t'(1) : '0;
            2: tbl_a[c][i][j] = 8'hff;
            3: tbl_a[c][i][j] = '0;
            default: tbl_a[c][i][j] = mm_pkg::elem_t'($random(seed));
          endcase
          tbl_b[c][i][j] = (c == 2) ? 8'hff : mm_pkg::elem_t'($random(seed));
        end
      end
      // C[i][j] is the sum over k of A[i][k]*B[k][j] in element width
      for (int i = 0; i < N; i++) begin
        for (int j = 0; j < N; j++) begin
          sum = '0;
          for (int k = 0; k < N; k++) begin
            sum = sum + tbl_a[c][i][k] * tbl_b[c][k][j];
          end
          tbl_c[c][i][j*`DWIDTH +: `DWIDTH] = sum;
        end
      end
    end
  endtask

  // A RAM word k is column k of A
  function automatic mm_pkg::row_t a_column(int c, int k);
    mm_pkg::row_t w;
    for (int i = 0; i < N; i++) begin
      w[i*`DWIDTH +: `DWIDTH] = tbl_a[c][i][k];
    end
    return w;
  endfunction

  function automatic mm_pkg::row_t b_row(int c, int k);
    mm_pkg::row_t w;
    for (int j = 0; j < N; j++) begin
      w[j*`DWIDTH +: `DWIDTH] = tbl_b[c][k][j];
    end
    return w;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic check_row(string name, mm_pkg::row_t exp, mm_pkg::row_t act);
    if (act !== exp) begin
      $display("ERR @%0t %s expected %h actual %h", $time, name, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("ERR @%0t %s expected %b actual %b", $time, name, exp, act);
      value_errs++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Host port and run tasks
  //////////////////////////////////////////////////////////////////////

  task automatic write_word(mm_pkg::addr_t addr, mm_pkg::row_t data, logic to_a, logic to_b);
    @(posedge clk_mem);
    #2;
    enable_writing_to_mem = 1'b1;
    addr_pi = addr;
    data_pi = data;
    we_a = to_a;
    we_b = to_b;
  endtask

  task automatic load_case(int c);
    for (int k = 0; k < N; k++) begin
      write_word(mm_pkg::addr_t'(k), a_column(c, k), 1'b1, 1'b0);
      write_word(mm_pkg::addr_t'(k), b_row(c, k), 1'b0, 1'b1);
    end
    @(posedge clk_mem);
    #2;
    enable_writing_to_mem = 1'b0;
    we_a = 1'b0;
    we_b = 1'b0;
  endtask

  task automatic pulse_start();
    @(posedge clk_mem);
    #2;
    start_mat_mul = 1'b1;
    @(posedge clk_mem);
    #2;
    start_mat_mul = 1'b0;
  endtask

  // A negative extra_at means no second start
  task automatic wait_done(int extra_at);
    int n;
    n = 0;
    while (n < DONE_LIMIT) begin
      @(posedge clk_mem);
      #2;
      start_mat_mul = (n == extra_at);
      @(negedge clk_mem);
      if (done_mat_mul) begin
        break;
      end
      n++;
    end
    if (n >= DONE_LIMIT) begin
      $display("done_mat_mul did not arrive within %0d cycles of start", DONE_LIMIT);
      other_errs++;
    end
  endtask

  task automatic check_quiet(int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clk_mem);
      check_bit("done_mat_mul", 1'b0, done_mat_mul);
    end
  endtask

  // Row i must show up exactly three edges after its address was driven
  task automatic read_results(int c);
    for (int cyc = 0; cyc < N + 3; cyc++) begin
      @(posedge clk_mem);
      #2;
      enable_reading_from_mem = (cyc < N);
      addr_pi = (cyc < N) ? mm_pkg::addr_t'(cyc) : '0;
      @(negedge clk_mem);
      if (cyc >= 3) begin
        check_row($sformatf("data_from_out_mat[row %0d]", cyc - 3), tbl_c[c][cyc-3],
                  data_from_out_mat);
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_mem) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Simulation timed out after %0d cycles", cycles);
      $display("Something failed");
      $finish;
    end
  end

  initial begin
    reset = 1'b1;
    enable_writing_to_mem = 1'b0;
    enable_reading_from_mem = 1'b0;
    addr_pi = '0;
    data_pi = '0;
    we_a = 1'b0;
    we_b = 1'b0;
    start_mat_mul = 1'b0;
    build_table();

    repeat (2) @(posedge clk_mem);
    #2;
    reset = 1'b0;
    @(negedge clk_mem);
    check_bit("done_mat_mul", 1'b0, done_mat_mul);
    check_row("data_from_out_mat", '0, data_from_out_mat);

    for (int c = 0; c < NUM_CASES; c++) begin
      load_case(c);
      pulse_start();
      if (tbl_mode[c] == MODE_RESTART) begin
        wait_done(2);
        check_quiet(DONE_LIMIT);
      end else begin
        wait_done(-1);
        check_quiet(1);
      end
      read_results(c);
    end

    $display("Value errors: %0d, other errors: %0d", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- mat_mul_top.f
+incdir+.
mm_pkg.sv
bank_ram.sv
mac_pe.sv
systolic_array.sv
mat_mul_ctrl.sv
mat_mul_top.sv
tb_clock_gen.sv
mat_mul_top_tb.sv

//--- Makefile
# Verilator build and run of the matrix multiplier testbench

TOP = mat_mul_top_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f mat_mul_top.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee $(LOG)
	@if grep -q "Something failed" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@grep -q "Everything OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
